// File: rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  result_src_t;
	typedef logic [1:0]  fwd_sel_t;

	// Major opcodes
	localparam logic [6:0] OP_R = 7'b0110011;
	localparam logic [6:0] OP_I = 7'b0010011;
	localparam logic [6:0] OP_L = 7'b0000011;
	localparam logic [6:0] OP_S = 7'b0100011;
	localparam logic [6:0] OP_B = 7'b1100011;
	localparam logic [6:0] OP_J = 7'b1101111;

	localparam alu_op_t ALU_ADD = 4'b0000;
	localparam alu_op_t ALU_SUB = 4'b0001;
	localparam alu_op_t ALU_AND = 4'b0010;
	localparam alu_op_t ALU_OR  = 4'b0011;
	localparam alu_op_t ALU_XOR = 4'b0100;
	localparam alu_op_t ALU_SLT = 4'b0101;
	localparam alu_op_t ALU_SHL = 4'b0110;
	localparam alu_op_t ALU_SHR = 4'b0111;
	localparam alu_op_t ALU_SGE = 4'b1000;
	localparam alu_op_t ALU_EQ  = 4'b1001;
	localparam alu_op_t ALU_NE  = 4'b1010;

	localparam result_src_t RES_ALU = 2'b00;
	localparam result_src_t RES_MEM = 2'b01;
	localparam result_src_t RES_PC4 = 2'b10;

	localparam fwd_sel_t FWD_RF  = 2'b00;
	localparam fwd_sel_t FWD_WB  = 2'b01;
	localparam fwd_sel_t FWD_MEM = 2'b10;

	typedef struct packed {
		logic        reg_write;
		result_src_t result_src;
		logic        mem_write;
		logic        jump;
		logic        branch;
		alu_op_t     alu_op;
		logic        alu_src;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t instruction;
		addr_t pc;
		addr_t pc_plus4;
	} if_id_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    rd1;
		word_t    rd2;
		word_t    imm;
		addr_t    pc;
		addr_t    pc_plus4;
	} id_ex_t;

	typedef struct packed {
		logic        reg_write;
		result_src_t result_src;
		logic        mem_write;
		word_t       alu_result;
		word_t       write_data;
		reg_idx_t    rd;
		addr_t       pc_plus4;
	} ex_mem_t;

	typedef struct packed {
		logic        reg_write;
		result_src_t result_src;
		word_t       alu_result;
		word_t       read_data;
		reg_idx_t    rd;
		addr_t       pc_plus4;
	} mem_wb_t;

endpackage

// File: rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; #(
	parameter addr_t RESET_PC = '0
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   stall_f,
	input  logic   stall_d,
	input  logic   flush_d,
	input  logic   pc_src,
	input  addr_t  pc_target,
	output addr_t  imem_addr,
	input  word_t  imem_data,
	output if_id_t if_id
);

	addr_t pc;
	addr_t pc_plus4;
	addr_t pc_next;

	assign pc_plus4  = pc + 32'd4;
	// Taken branch or jal from execute wins
	assign pc_next   = pc_src ? pc_target : pc_plus4;
	assign imem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (!stall_f) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '0;
		end else if (flush_d) begin
			if_id.valid <= 1'b0;
		end else if (!stall_d) begin
			if_id <= '{valid: 1'b1, instruction: imem_data, pc: pc, pc_plus4: pc_plus4};
		end
	end

	// A load-use stall never coincides with a redirect from execute
	assert property (@(posedge clk) disable iff (!rst_n) !(stall_d && flush_d))
		else $error("decode stalled and flushed in the same cycle");

endmodule

// File: rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush_e,
	input  if_id_t   if_id,
	input  word_t    rd1,
	input  word_t    rd2,
	output reg_idx_t rs1_d,
	output reg_idx_t rs2_d,
	output id_ex_t   id_ex
);

	word_t      instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	ctrl_t      ctrl;
	word_t      imm;
	logic       use_rs1;
	logic       use_rs2;
	logic       use_rd;
	reg_idx_t   rd_d;
	id_ex_t     id_ex_next;

	assign instr  = if_id.instruction;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	// Shared by R and I formats, sub only exists for R
	function automatic alu_op_t alu_decode(logic [2:0] f3, logic is_sub);
		case (f3)
			3'b000:  return is_sub ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SHL;
			3'b010:  return ALU_SLT;
			3'b100:  return ALU_XOR;
			3'b101:  return ALU_SHR;
			3'b110:  return ALU_OR;
			3'b111:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	always_comb begin
		ctrl    = '0;
		imm     = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd  = 1'b0;
		if (if_id.valid) begin
			case (opcode)
				OP_R: begin
					ctrl.reg_write = 1'b1;
					ctrl.alu_op    = alu_decode(funct3, instr[30]);
					use_rs1        = 1'b1;
					use_rs2        = 1'b1;
					use_rd         = 1'b1;
				end
				OP_I: begin
					ctrl.reg_write = 1'b1;
					ctrl.alu_op    = alu_decode(funct3, 1'b0);
					ctrl.alu_src   = 1'b1;
					imm            = {{20{instr[31]}}, instr[31:20]};
					use_rs1        = 1'b1;
					use_rd         = 1'b1;
				end
				OP_L: begin
					ctrl.reg_write  = 1'b1;
					ctrl.result_src = RES_MEM;
					ctrl.alu_src    = 1'b1;
					imm             = {{20{instr[31]}}, instr[31:20]};
					use_rs1         = 1'b1;
					use_rd          = 1'b1;
				end
				OP_S: begin
					ctrl.mem_write = 1'b1;
					ctrl.alu_src   = 1'b1;
					imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
					use_rs1        = 1'b1;
					use_rs2        = 1'b1;
				end
				OP_B: begin
					ctrl.branch = 1'b1;
					case (funct3)
						3'b000:  ctrl.alu_op = ALU_EQ;
						3'b001:  ctrl.alu_op = ALU_NE;
						3'b100:  ctrl.alu_op = ALU_SLT;
						3'b101:  ctrl.alu_op = ALU_SGE;
						default: ctrl.branch = 1'b0;
					endcase
					imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
				OP_J: begin
					ctrl.reg_write  = 1'b1;
					ctrl.result_src = RES_PC4;
					ctrl.jump       = 1'b1;
					imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
					use_rd = 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Unused fields read as x0 so they never trigger hazards
	assign rs1_d = use_rs1 ? instr[19:15] : '0;
	assign rs2_d = use_rs2 ? instr[24:20] : '0;
	assign rd_d  = use_rd ? instr[11:7] : '0;

	assign id_ex_next = '{
		ctrl:     flush_e ? '0 : ctrl,
		rs1:      rs1_d,
		rs2:      rs2_d,
		rd:       rd_d,
		rd1:      rd1,
		rd2:      rd2,
		imm:      imm,
		pc:       if_id.pc,
		pc_plus4: if_id.pc_plus4
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  logic     we,
	input  word_t    wdata,
	output word_t    rd1,
	output word_t    rd2
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Writeback result bypasses to decode in the same cycle
	assign rd1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

// File: rv_hazard_unit.sv
`timescale 1ns/1ps

module rv_hazard_unit import rv_pkg::*; (
	input  reg_idx_t rs1_d,
	input  reg_idx_t rs2_d,
	input  id_ex_t   id_ex,
	input  ex_mem_t  ex_mem,
	input  mem_wb_t  mem_wb,
	input  logic     pc_src,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output logic     stall_f,
	output logic     stall_d,
	output logic     flush_d,
	output logic     flush_e
);

	logic lw_stall;

	// Youngest producer first
	function automatic fwd_sel_t fwd_select(reg_idx_t rs);
		if (rs == '0) begin
			return FWD_RF;
		end else if (ex_mem.reg_write && ex_mem.rd == rs) begin
			return FWD_MEM;
		end else if (mem_wb.reg_write && mem_wb.rd == rs) begin
			return FWD_WB;
		end
		return FWD_RF;
	endfunction

	always_comb begin
		fwd_a = fwd_select(id_ex.rs1);
		fwd_b = fwd_select(id_ex.rs2);
		// A live instruction never takes load data from the memory stage
		if (id_ex.ctrl != '0 && ex_mem.reg_write && ex_mem.result_src == RES_MEM) begin
			assert (fwd_a != FWD_MEM && fwd_b != FWD_MEM)
				else $error("load data forwarded from the memory stage");
		end
	end

	// Load in execute feeding the instruction in decode
	assign lw_stall = id_ex.ctrl.result_src == RES_MEM && id_ex.rd != '0 &&
		(id_ex.rd == rs1_d || id_ex.rd == rs2_d);

	assign stall_f = lw_stall;
	assign stall_d = lw_stall;
	assign flush_d = pc_src;
	assign flush_e = lw_stall || pc_src;

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  id_ex_t   id_ex,
	input  fwd_sel_t fwd_a,
	input  fwd_sel_t fwd_b,
	output word_t    alu_result_m,
	input  word_t    result_w,
	output logic     pc_src,
	output addr_t    pc_target,
	output ex_mem_t  ex_mem
);

	word_t src_a;
	word_t src_b;
	word_t write_data;
	word_t alu_result;

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val);
		case (sel)
			FWD_WB:  return result_w;
			FWD_MEM: return alu_result_m;
			default: return rf_val;
		endcase
	endfunction

	assign alu_result_m = ex_mem.alu_result;

	always_comb begin
		src_a      = fwd_mux(fwd_a, id_ex.rd1);
		write_data = fwd_mux(fwd_b, id_ex.rd2);
	end

	assign src_b = id_ex.ctrl.alu_src ? id_ex.imm : write_data;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_ADD: alu_result = src_a + src_b;
			ALU_SUB: alu_result = src_a - src_b;
			ALU_AND: alu_result = src_a & src_b;
			ALU_OR:  alu_result = src_a | src_b;
			ALU_XOR: alu_result = src_a ^ src_b;
			ALU_SLT: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
			ALU_SHL: alu_result = src_a << src_b[4:0];
			ALU_SHR: alu_result = src_a >> src_b[4:0];
			ALU_SGE: alu_result = {31'b0, $signed(src_a) >= $signed(src_b)};
			ALU_EQ:  alu_result = {31'b0, src_a == src_b};
			ALU_NE:  alu_result = {31'b0, src_a != src_b};
			default: alu_result = '0;
		endcase
	end

	// Any nonzero comparison result means taken
	assign pc_src    = id_ex.ctrl.jump || (id_ex.ctrl.branch && alu_result != '0);
	assign pc_target = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= '{
				reg_write:  id_ex.ctrl.reg_write,
				result_src: id_ex.ctrl.result_src,
				mem_write:  id_ex.ctrl.mem_write,
				alu_result: alu_result,
				write_data: write_data,
				rd:         id_ex.rd,
				pc_plus4:   id_ex.pc_plus4
			};
		end
	end

endmodule

// File: rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback import rv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_mem,
	input  word_t   dmem_rdata,
	output mem_wb_t mem_wb,
	output word_t   result_w
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb <= '{
				reg_write:  ex_mem.reg_write,
				result_src: ex_mem.result_src,
				alu_result: ex_mem.alu_result,
				read_data:  dmem_rdata,
				rd:         ex_mem.rd,
				pc_plus4:   ex_mem.pc_plus4
			};
		end
	end

	always_comb begin
		case (mem_wb.result_src)
			RES_MEM: result_w = mem_wb.read_data;
			RES_PC4: result_w = mem_wb.pc_plus4;
			default: result_w = mem_wb.alu_result;
		endcase
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_wb.reg_write |-> mem_wb.result_src != 2'b11)
		else $error("writeback source undefined for a register write");

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
	parameter int    NUM_REGS = 32,
	parameter addr_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  rst_n,
	output addr_t imem_addr,
	input  word_t imem_data,
	output logic  dmem_we,
	output addr_t dmem_addr,
	output word_t dmem_wdata,
	input  word_t dmem_rdata
);

	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	mem_wb_t  mem_wb;
	reg_idx_t rs1_d;
	reg_idx_t rs2_d;
	word_t    rd1;
	word_t    rd2;
	word_t    result_w;
	logic     pc_src;
	addr_t    pc_target;
	logic     stall_f;
	logic     stall_d;
	logic     flush_d;
	logic     flush_e;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	// Memory stage drives the data port directly
	assign dmem_we    = ex_mem.mem_write;
	assign dmem_addr  = ex_mem.alu_result;
	assign dmem_wdata = ex_mem.write_data;

	rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall_f   (stall_f),
		.stall_d   (stall_d),
		.flush_d   (flush_d),
		.pc_src    (pc_src),
		.pc_target (pc_target),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.if_id     (if_id)
	);

	rv_decode u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush_e (flush_e),
		.if_id   (if_id),
		.rd1     (rd1),
		.rd2     (rd2),
		.rs1_d   (rs1_d),
		.rs2_d   (rs2_d),
		.id_ex   (id_ex)
	);

	rv_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
		.clk   (clk),
		.rst_n (rst_n),
		.rs1   (rs1_d),
		.rs2   (rs2_d),
		.rd    (mem_wb.rd),
		.we    (mem_wb.reg_write),
		.wdata (result_w),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	rv_execute u_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.id_ex        (id_ex),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.alu_result_m (),
		.result_w     (result_w),
		.pc_src       (pc_src),
		.pc_target    (pc_target),
		.ex_mem       (ex_mem)
	);

	rv_writeback u_writeback (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_mem     (ex_mem),
		.dmem_rdata (dmem_rdata),
		.mem_wb     (mem_wb),
		.result_w   (result_w)
	);

	rv_hazard_unit u_hazard_unit (
		.rs1_d   (rs1_d),
		.rs2_d   (rs2_d),
		.id_ex   (id_ex),
		.ex_mem  (ex_mem),
		.mem_wb  (mem_wb),
		.pc_src  (pc_src),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b),
		.stall_f (stall_f),
		.stall_d (stall_d),
		.flush_d (flush_d),
		.flush_e (flush_e)
	);

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_NS = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

	localparam int PROGRAMS = 5;
	localparam int PROG_LEN = 150;
	localparam int HALT_IDX = PROG_LEN + 31;
	localparam int TIMEOUT  = PROGRAMS * (3 * PROG_LEN + 31 + 50);

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        dmem_we;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	integer      seed;
	int          cycles;

	tb_clock u_clock (.clk(clk));

	rv_core #(.NUM_REGS(32), .RESET_PC(32'h0)) u_rv_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	// Both memories answer in the same cycle
	assign imem_data  = imem[imem_addr[11:2]];
	assign dmem_rdata = dmem[dmem_addr[11:2]];

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp)
			else fail_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
	endtask

	// One clock cycle, bounded by the run limit
	task automatic tick();
		@(negedge clk);
		cycles++;
		assert (cycles < TIMEOUT)
			else fail_run("Timeout: the core did not finish all programs within the cycle limit");
	endtask

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	// Differs in every address bit
	function automatic logic [31:0] fill_word(int idx);
		return (idx * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
	endfunction

	// Mostly x0..x7 so neighbours share registers
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = rnd();
		return (r[1:0] == 2'b00) ? r[8:4] : {2'b00, r[6:4]};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] gen_instr(int idx);
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		int          hop;
		r   = rnd();
		rd  = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		f3  = r[9:7];
		// Forward only, at most to the first dump store
		hop = 1 + int'(r[6:4]);
		if (idx + hop > PROG_LEN) begin
			hop = PROG_LEN - idx;
		end
		case (r[3:0])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
				// Code 011 stands in for sub
				if (f3 == 3'b011) begin
					return enc_r(7'h20, rs2, rs1, 3'b000, rd);
				end
				return enc_r(7'h00, rs2, rs1, f3, rd);
			end
			4'd6, 4'd7, 4'd8, 4'd9: begin
				if (f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101) begin
					f3 = 3'b000;
				end
				return enc_i(r[31:20], rs1, f3, rd, 7'b0010011);
			end
			4'd10, 4'd11: return enc_i({2'b00, r[17:10], 2'b00}, 5'd0, 3'b010, rd, 7'b0000011);
			4'd12, 4'd13: return enc_s({2'b00, r[17:10], 2'b00}, rs2, 5'd0);
			4'd14:        return enc_b(13'(hop * 4), rs2, rs1, {r[8], 1'b0, r[7]});
			default:      return enc_j(21'(hop * 4), rd);
		endcase
	endfunction

	task automatic load_program();
		int i;
		for (i = 0; i < 1024; i++) begin
			imem[i] = 32'h0;
			dmem[i] = fill_word(i);
		end
		for (i = 0; i < PROG_LEN; i++) begin
			imem[i] = gen_instr(i);
		end
		// Dump x1..x31 above the data area, then spin
		for (i = 1; i < 32; i++) begin
			imem[PROG_LEN + i - 1] = enc_s(12'(32'h400 + 4 * i), 5'(i), 5'd0);
		end
		imem[HALT_IDX] = enc_j(21'd0, 5'd0);
	endtask

	function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b100:  return a ^ b;
			3'b101:  return a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// Architectural execution, one instruction per step
	task automatic run_model();
		logic [31:0] x [32];
		logic [31:0] mem [1024];
		logic [31:0] pc;
		logic [31:0] next;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [31:0] imm_i;
		logic        taken;
		int          i;
		int          steps;
		exp_addr.delete();
		exp_data.delete();
		for (i = 0; i < 32; i++) begin
			x[i] = 32'h0;
		end
		for (i = 0; i < 1024; i++) begin
			mem[i] = dmem[i];
		end
		pc    = 32'h0;
		steps = 0;
		while (pc != 32'(HALT_IDX * 4) && steps < 1000) begin
			ins   = imem[pc[11:2]];
			a     = x[ins[19:15]];
			b     = x[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			next  = pc + 4;
			case (ins[6:0])
				7'b0110011: x[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
				7'b0010011: x[ins[11:7]] = alu_ref(ins[14:12], 1'b0, a, imm_i);
				7'b0000011: begin
					ea = a + imm_i;
					x[ins[11:7]] = mem[ea[11:2]];
				end
				7'b0100011: begin
					ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					exp_addr.push_back(ea);
					exp_data.push_back(b);
					mem[ea[11:2]] = b;
				end
				7'b1100011: begin
					case (ins[14:12])
						3'b000:  taken = a == b;
						3'b001:  taken = a != b;
						3'b100:  taken = $signed(a) < $signed(b);
						default: taken = $signed(a) >= $signed(b);
					endcase
					if (taken) begin
						next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
					end
				end
				7'b1101111: begin
					x[ins[11:7]] = pc + 4;
					next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				default: fail_run("Model met an opcode outside the generated set");
			endcase
			x[0] = 32'h0;
			pc   = next;
			steps++;
		end
		assert (pc == 32'(HALT_IDX * 4))
			else fail_run("Model never reached the final jal");
	endtask

	task automatic run_program(int p);
		int run_cyc;
		int st_count;
		int drain;
		rst_n = 1'b0;
		load_program();
		run_model();
		repeat (10) tick();
		check_word($sformatf("prog%0d reset pc", p), 32'h0, imem_addr);
		assert (!dmem_we)
			else fail_run("Store enable was high while the core was held in reset");
		rst_n    = 1'b1;
		run_cyc  = 0;
		st_count = 0;
		drain    = 0;
		// A few idle cycles after the last store catch extra ones
		while (drain < 8) begin
			tick();
			run_cyc++;
			if (dmem_we) begin
				assert (run_cyc >= 3)
					else fail_run("A store reached memory before any instruction could");
				assert (st_count < exp_addr.size())
					else fail_run($sformatf("Program %0d made more stores than the model", p));
				check_word($sformatf("prog%0d store%0d addr", p, st_count),
					exp_addr[st_count], dmem_addr);
				check_word($sformatf("prog%0d store%0d data", p, st_count),
					exp_data[st_count], dmem_wdata);
				dmem[dmem_addr[11:2]] = dmem_wdata;
				st_count++;
			end
			if (st_count == exp_addr.size()) begin
				drain++;
			end
		end
	endtask

	initial begin
		int p;
		seed   = 32'h5a06_6584;
		cycles = 0;
		rst_n  = 1'b0;
		for (p = 0; p < PROGRAMS; p++) begin
			run_program(p);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: filelist.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_hazard_unit.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

// File: Makefile
TOP = tb_rv_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
